//--- hw/cpuPkg.sv
package cpuPkg;

  localparam int dataBits = 32;
  localparam int regNoBits = 4;
  localparam int immBits = 16;
  localparam int op1Bits = 6;
  localparam int op2Bits = 8;

  typedef logic [dataBits-1:0] word;
  typedef logic [regNoBits-1:0] regNo;

  localparam word instSize = 32'd4;

  // Low bit of each instruction field
  localparam int op1Lo = 26;
  localparam int op2Lo = 18;
  localparam int immLo = 8;
  localparam int rdLo = 8;
  localparam int rsLo = 4;
  localparam int rtLo = 0;

  // APB regions live in paddr[17:16]
  localparam int regionHi = 17;
  localparam int regionLo = 16;
  localparam logic [1:0] regionImem = 2'd0;
  localparam logic [1:0] regionDmem = 2'd1;
  localparam logic [1:0] regionCtrl = 2'd2;
  localparam int runBit = 0;

  typedef enum logic [op1Bits-1:0] {
    ALUR = 6'b000000, BEQ = 6'b001000, BLT = 6'b001001, BLE = 6'b001010,
    BNE = 6'b001011, JAL = 6'b001100, LW = 6'b010010, SW = 6'b011010,
    ADDI = 6'b100000, ANDI = 6'b100100, ORI = 6'b100101, XORI = 6'b100110
  } op1Code;

  typedef enum logic [op2Bits-1:0] {
    EQ = 8'b00001000, LT = 8'b00001001, LE = 8'b00001010, NE = 8'b00001011,
    ADD = 8'b00100000, AND = 8'b00100100, OR = 8'b00100101, XOR = 8'b00100110,
    SUB = 8'b00101000, NAND = 8'b00101100, NOR = 8'b00101101,
    NXOR = 8'b00101110, RSHF = 8'b00110000, LSHF = 8'b00110001
  } op2Code;

  typedef struct packed {
    logic isBr;
    logic isJmp;
    logic rdMem;
    logic wrMem;
    logic wrReg;
  } ctrlSig;

  typedef struct packed {
    word pc;
    word inst;
    logic valid;
  } fetchToDecode;

  typedef struct packed {
    word pc;
    op1Code op1;
    op2Code op2;
    word imm;
    word val1;
    word val2;
    regNo wregNo;
    ctrlSig ctrl;
  } decodeToExec;

  typedef struct packed {
    word aluOut;
    word storeVal;
    regNo wregNo;
    logic rdMem;
    logic wrMem;
    logic wrReg;
  } execToMem;

  typedef struct packed {
    regNo wregNo;
    word value;
    logic wrReg;
  } memToWb;

  // One bypass source for decode
  typedef struct packed {
    logic wrReg;
    regNo wregNo;
    word value;
  } regForward;

  typedef struct packed {
    logic taken;
    word target;
  } redirect;

  typedef struct packed {
    logic psel;
    logic penable;
    logic pwrite;
    word paddr;
    word pwdata;
  } apbReq;

  typedef struct packed {
    word prdata;
    logic pready;
    logic pslverr;
  } apbRsp;

  // Single-cycle host request to one memory, addr is a word index
  typedef struct packed {
    logic en;
    logic we;
    word addr;
    word wdata;
  } memPort;

endpackage

//--- hw/fetchStage.sv
`timescale 1ns/1ps

module fetchStage #(
  parameter int imemAddrBits = 12,
  parameter cpuPkg::word startPc = 32'h100
) (
  input  logic clk,
  input  logic reset,
  input  logic run,
  input  logic stall,
  input  cpuPkg::redirect redir,
  input  cpuPkg::memPort imemPort,
  output cpuPkg::fetchToDecode toDecode
);

  localparam int offBits = $clog2(cpuPkg::instSize);
  localparam int imemWords = 1 << (imemAddrBits - offBits);

  cpuPkg::word imem [imemWords];
  cpuPkg::word pc;
  cpuPkg::word inst;

  assign inst = imem[pc[imemAddrBits-1:offBits]];

  // Host loads the program here while the core is halted
  always_ff @(posedge clk) begin
    if (imemPort.en && imemPort.we) begin
      imem[imemPort.addr[imemAddrBits-offBits-1:0]] <= imemPort.wdata;
    end
  end

  // Halted core parks at the start address
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      pc <= startPc;
    end else if (!run) begin
      pc <= startPc;
    end else if (redir.taken) begin
      pc <= redir.target;
    end else if (!stall) begin
      pc <= pc + cpuPkg::instSize;
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      toDecode <= '0;
    end else if (redir.taken) begin
      toDecode.valid <= 1'b0;
    end else if (!stall) begin
      toDecode <= '{pc: pc, inst: inst, valid: run};
    end
  end

endmodule

//--- hw/decodeStage.sv
`timescale 1ns/1ps

module decodeStage (
  input  logic clk,
  input  logic reset,
  input  cpuPkg::fetchToDecode fromFetch,
  input  cpuPkg::regForward exFwd,
  input  cpuPkg::regForward memFwd,
  input  cpuPkg::memToWb wb,
  input  logic flush,
  output logic stall,
  output cpuPkg::decodeToExec toExec
);

  localparam int regWords = 1 << cpuPkg::regNoBits;

  cpuPkg::word regs [regWords];
  cpuPkg::word inst;
  cpuPkg::op1Code op1;
  cpuPkg::op2Code op2;
  logic [cpuPkg::immBits-1:0] immField;
  cpuPkg::word immExt;
  cpuPkg::regNo rd;
  cpuPkg::regNo rs;
  cpuPkg::regNo rt;
  cpuPkg::regNo wregNo;
  logic isImmOp;
  logic useRt;
  cpuPkg::ctrlSig ctrl;
  cpuPkg::word val1;
  cpuPkg::word val2;

  // Youngest producer wins, register file is the fallback
  function automatic cpuPkg::word pickOperand(
    input cpuPkg::regNo r,
    input cpuPkg::word fileVal,
    input cpuPkg::regForward ex,
    input cpuPkg::regForward mem,
    input cpuPkg::memToWb wbIn
  );
    if (ex.wrReg && ex.wregNo == r) begin
      return ex.value;
    end else if (mem.wrReg && mem.wregNo == r) begin
      return mem.value;
    end else if (wbIn.wrReg && wbIn.wregNo == r) begin
      return wbIn.value;
    end
    return fileVal;
  endfunction

  assign inst = fromFetch.inst;
  assign op1 = cpuPkg::op1Code'(inst[cpuPkg::op1Lo +: cpuPkg::op1Bits]);
  assign op2 = cpuPkg::op2Code'(inst[cpuPkg::op2Lo +: cpuPkg::op2Bits]);
  assign immField = inst[cpuPkg::immLo +: cpuPkg::immBits];
  assign rd = inst[cpuPkg::rdLo +: cpuPkg::regNoBits];
  assign rs = inst[cpuPkg::rsLo +: cpuPkg::regNoBits];
  assign rt = inst[cpuPkg::rtLo +: cpuPkg::regNoBits];

  assign immExt = {{(cpuPkg::dataBits - cpuPkg::immBits){immField[cpuPkg::immBits-1]}},
                   immField};

  assign isImmOp = op1 inside {cpuPkg::ADDI, cpuPkg::ANDI, cpuPkg::ORI, cpuPkg::XORI};
  // JAL, LW and immediate ops use rt as destination only
  assign useRt = !(op1 == cpuPkg::JAL || op1 == cpuPkg::LW || isImmOp);
  assign wregNo = (op1 == cpuPkg::ALUR) ? rd : rt;

  always_comb begin
    ctrl = '0;
    if (fromFetch.valid) begin
      ctrl.isBr = op1 inside {cpuPkg::BEQ, cpuPkg::BLT, cpuPkg::BLE, cpuPkg::BNE,
                              cpuPkg::JAL};
      ctrl.isJmp = op1 == cpuPkg::JAL;
      ctrl.rdMem = op1 == cpuPkg::LW;
      ctrl.wrMem = op1 == cpuPkg::SW;
      ctrl.wrReg = !((ctrl.isBr && !ctrl.isJmp) || ctrl.wrMem);
    end
  end

  assign val1 = pickOperand(rs, regs[rs], exFwd, memFwd, wb);
  assign val2 = pickOperand(rt, regs[rt], exFwd, memFwd, wb);

  // Load result is not ready until the memory stage
  assign stall = fromFetch.valid && toExec.ctrl.rdMem &&
                 (rs == toExec.wregNo || (useRt && rt == toExec.wregNo));

  // Writeback stage
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      for (int i = 0; i < regWords; i++) begin
        regs[i] <= '0;
      end
    end else if (wb.wrReg) begin
      regs[wb.wregNo] <= wb.value;
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      toExec <= '0;
    end else if (flush || stall) begin
      toExec <= '0;
    end else begin
      toExec <= '{pc: fromFetch.pc, op1: op1, op2: op2, imm: immExt, val1: val1,
                  val2: val2, wregNo: wregNo, ctrl: ctrl};
    end
  end

endmodule

//--- hw/executeStage.sv
`timescale 1ns/1ps

module executeStage (
  input  logic clk,
  input  logic reset,
  input  cpuPkg::decodeToExec fromDecode,
  output cpuPkg::regForward exFwd,
  output cpuPkg::redirect redir,
  output cpuPkg::execToMem toMem
);

  logic signed [cpuPkg::dataBits-1:0] opA;
  logic signed [cpuPkg::dataBits-1:0] opB;
  cpuPkg::word imm;
  cpuPkg::word immOffset;
  cpuPkg::word aluOut;
  logic brCond;
  cpuPkg::ctrlSig ctrl;

  assign opA = fromDecode.val1;
  assign opB = fromDecode.val2;
  assign imm = fromDecode.imm;
  assign ctrl = fromDecode.ctrl;
  assign immOffset = imm * cpuPkg::instSize;

  always_comb begin
    case (fromDecode.op1)
      cpuPkg::ALUR: begin
        case (fromDecode.op2)
          cpuPkg::EQ:   aluOut = cpuPkg::word'(opA == opB);
          cpuPkg::LT:   aluOut = cpuPkg::word'(opA < opB);
          cpuPkg::LE:   aluOut = cpuPkg::word'(opA <= opB);
          cpuPkg::NE:   aluOut = cpuPkg::word'(opA != opB);
          cpuPkg::ADD:  aluOut = opA + opB;
          cpuPkg::AND:  aluOut = opA & opB;
          cpuPkg::OR:   aluOut = opA | opB;
          cpuPkg::XOR:  aluOut = opA ^ opB;
          cpuPkg::SUB:  aluOut = opA - opB;
          cpuPkg::NAND: aluOut = ~(opA & opB);
          cpuPkg::NOR:  aluOut = ~(opA | opB);
          cpuPkg::NXOR: aluOut = opA ~^ opB;
          // Logical shifts, amounts of 32 and up clear the word
          cpuPkg::RSHF: aluOut = fromDecode.val1 >> fromDecode.val2;
          cpuPkg::LSHF: aluOut = fromDecode.val1 << fromDecode.val2;
          default:      aluOut = '0;
        endcase
      end
      cpuPkg::JAL:  aluOut = fromDecode.pc + cpuPkg::instSize;
      cpuPkg::LW,
      cpuPkg::SW,
      cpuPkg::ADDI: aluOut = opA + imm;
      cpuPkg::ANDI: aluOut = opA & imm;
      cpuPkg::ORI:  aluOut = opA | imm;
      cpuPkg::XORI: aluOut = opA ^ imm;
      default:      aluOut = '0;
    endcase
  end

  // Signed branch compares
  always_comb begin
    case (fromDecode.op1)
      cpuPkg::BEQ: brCond = opA == opB;
      cpuPkg::BLT: brCond = opA < opB;
      cpuPkg::BLE: brCond = opA <= opB;
      cpuPkg::BNE: brCond = opA != opB;
      default:     brCond = 1'b0;
    endcase
  end

  assign redir = '{
    taken: (ctrl.isBr && !ctrl.isJmp && brCond) || ctrl.isJmp,
    target: ctrl.isJmp ? fromDecode.val1 + immOffset : fromDecode.pc + immOffset
  };

  assign exFwd = '{wrReg: ctrl.wrReg, wregNo: fromDecode.wregNo, value: aluOut};

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      toMem <= '0;
    end else begin
      toMem <= '{aluOut: aluOut, storeVal: fromDecode.val2, wregNo: fromDecode.wregNo,
                 rdMem: ctrl.rdMem, wrMem: ctrl.wrMem, wrReg: ctrl.wrReg};
    end
  end

endmodule

//--- hw/memoryStage.sv
`timescale 1ns/1ps

module memoryStage #(
  parameter int dmemAddrBits = 12,
  parameter cpuPkg::word ledrAddr = 32'hFFFFF020
) (
  input  logic clk,
  input  logic reset,
  input  cpuPkg::execToMem fromExec,
  input  cpuPkg::memPort dmemPort,
  output cpuPkg::word dmemRdata,
  output cpuPkg::regForward memFwd,
  output cpuPkg::memToWb toWb,
  output logic [9:0] ledr
);

  localparam int offBits = $clog2(cpuPkg::instSize);
  localparam int dmemWords = 1 << (dmemAddrBits - offBits);

  cpuPkg::word dmem [dmemWords];
  logic [dmemAddrBits-offBits-1:0] coreIndex;
  logic isLedr;
  cpuPkg::word loadVal;
  cpuPkg::word result;

  assign coreIndex = fromExec.aluOut[dmemAddrBits-1:offBits];
  assign isLedr = fromExec.aluOut == ledrAddr;

  // LED register reads back through the load path
  assign loadVal = isLedr ? cpuPkg::word'(ledr) : dmem[coreIndex];
  assign result = fromExec.rdMem ? loadVal : fromExec.aluOut;

  // Host port only moves while halted, so the two writers never collide
  always_ff @(posedge clk) begin
    if (fromExec.wrMem && !isLedr) begin
      dmem[coreIndex] <= fromExec.storeVal;
    end else if (dmemPort.en && dmemPort.we) begin
      dmem[dmemPort.addr[dmemAddrBits-offBits-1:0]] <= dmemPort.wdata;
    end
  end

  assign dmemRdata = dmem[dmemPort.addr[dmemAddrBits-offBits-1:0]];

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      ledr <= '0;
    end else if (fromExec.wrMem && isLedr) begin
      ledr <= fromExec.storeVal[9:0];
    end
  end

  assign memFwd = '{wrReg: fromExec.wrReg, wregNo: fromExec.wregNo, value: result};

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      toWb <= '0;
    end else begin
      toWb <= '{wregNo: fromExec.wregNo, value: result, wrReg: fromExec.wrReg};
    end
  end

endmodule

//--- hw/apbControl.sv
`timescale 1ns/1ps

module apbControl (
  input  logic clk,
  input  logic reset,
  input  cpuPkg::apbReq apbIn,
  output cpuPkg::apbRsp apbOut,
  input  cpuPkg::word dmemRdata,
  output logic run,
  output cpuPkg::memPort imemPort,
  output cpuPkg::memPort dmemPort
);

  logic access;
  logic [1:0] region;
  logic badOffset;
  logic error;
  cpuPkg::word wordIndex;
  cpuPkg::word readData;

  assign access = apbIn.psel && apbIn.penable;
  assign region = apbIn.paddr[cpuPkg::regionHi:cpuPkg::regionLo];
  assign badOffset = apbIn.paddr[cpuPkg::regionLo-1:0] != '0;
  assign wordIndex = apbIn.paddr >> $clog2(cpuPkg::instSize);

  // Memories are only open to the host while the core is halted
  always_comb begin
    error = 1'b0;
    readData = '0;
    case (region)
      cpuPkg::regionImem: error = run;
      cpuPkg::regionDmem: begin
        error = run;
        readData = dmemRdata;
      end
      cpuPkg::regionCtrl: begin
        error = apbIn.pwrite && badOffset;
        readData = cpuPkg::word'(run) << cpuPkg::runBit;
      end
      default: error = 1'b1;
    endcase
  end

  // Zero wait states
  assign apbOut = '{prdata: readData, pready: 1'b1, pslverr: access && error};

  assign imemPort = '{en: access && !error && region == cpuPkg::regionImem,
                      we: apbIn.pwrite, addr: wordIndex, wdata: apbIn.pwdata};
  assign dmemPort = '{en: access && !error && region == cpuPkg::regionDmem,
                      we: apbIn.pwrite, addr: wordIndex, wdata: apbIn.pwdata};

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      run <= 1'b0;
    end else if (access && apbIn.pwrite && !error && region == cpuPkg::regionCtrl) begin
      run <= apbIn.pwdata[cpuPkg::runBit];
    end
  end

endmodule

//--- hw/pipelineCore.sv
`timescale 1ns/1ps

module pipelineCore #(
  parameter int imemAddrBits = 12,
  parameter int dmemAddrBits = 12,
  parameter cpuPkg::word startPc = 32'h100,
  parameter cpuPkg::word ledrAddr = 32'hFFFFF020
) (
  input  logic clk,
  input  logic reset,
  input  cpuPkg::apbReq apbIn,
  output cpuPkg::apbRsp apbOut,
  output logic [9:0] ledr
);

  logic run;
  logic stall;
  cpuPkg::memPort imemPort;
  cpuPkg::memPort dmemPort;
  cpuPkg::word dmemRdata;
  cpuPkg::fetchToDecode fetchLatch;
  cpuPkg::decodeToExec decodeLatch;
  cpuPkg::execToMem execLatch;
  cpuPkg::memToWb memLatch;
  cpuPkg::regForward exFwd;
  cpuPkg::regForward memFwd;
  cpuPkg::redirect redir;

  apbControl apbCtl (
    .clk(clk),
    .reset(reset),
    .apbIn(apbIn),
    .apbOut(apbOut),
    .dmemRdata(dmemRdata),
    .run(run),
    .imemPort(imemPort),
    .dmemPort(dmemPort)
  );

  fetchStage #(
    .imemAddrBits(imemAddrBits),
    .startPc(startPc)
  ) fetch (
    .clk(clk),
    .reset(reset),
    .run(run),
    .stall(stall),
    .redir(redir),
    .imemPort(imemPort),
    .toDecode(fetchLatch)
  );

  // A taken redirect flushes the two younger instructions
  decodeStage decode (
    .clk(clk),
    .reset(reset),
    .fromFetch(fetchLatch),
    .exFwd(exFwd),
    .memFwd(memFwd),
    .wb(memLatch),
    .flush(redir.taken),
    .stall(stall),
    .toExec(decodeLatch)
  );

  executeStage execute (
    .clk(clk),
    .reset(reset),
    .fromDecode(decodeLatch),
    .exFwd(exFwd),
    .redir(redir),
    .toMem(execLatch)
  );

  memoryStage #(
    .dmemAddrBits(dmemAddrBits),
    .ledrAddr(ledrAddr)
  ) memory (
    .clk(clk),
    .reset(reset),
    .fromExec(execLatch),
    .dmemPort(dmemPort),
    .dmemRdata(dmemRdata),
    .memFwd(memFwd),
    .toWb(memLatch),
    .ledr(ledr)
  );

endmodule

//--- testbench/coreTb.sv
`timescale 1ns/1ps

module coreTb;

  localparam int clkPeriod = 8;
  localparam int testCount = 6;
  localparam int cyclesPerTest = 400;
  localparam int runCycles = 300;
  localparam cpuPkg::word startPc = 32'h100;
  localparam cpuPkg::word ledrAddr = 32'hFFFFF020;
  // APB region bases, region sits in paddr[17:16]
  localparam cpuPkg::word imemBase = 32'h00000;
  localparam cpuPkg::word dmemBase = 32'h10000;
  localparam cpuPkg::word ctrlAddr = 32'h20000;
  localparam cpuPkg::word unmappedAddr = 32'h30000;

  logic clk;
  logic reset;
  cpuPkg::apbReq apbIn;
  cpuPkg::apbRsp apbOut;
  logic [9:0] ledr;

  cpuPkg::word progWords[$];
  int checkCount;
  int errorCount;

  pipelineCore #(
    .imemAddrBits(12),
    .dmemAddrBits(12),
    .startPc(startPc),
    .ledrAddr(ledrAddr)
  ) dut (
    .clk(clk),
    .reset(reset),
    .apbIn(apbIn),
    .apbOut(apbOut),
    .ledr(ledr)
  );

  always #(clkPeriod / 2) clk = ~clk;

  // Register-register format: op1 31:26, op2 25:18, rd 11:8, rs 7:4, rt 3:0
  function automatic cpuPkg::word aluInst(cpuPkg::op2Code op2, int rd, int rs, int rt);
    cpuPkg::word w;
    w = '0;
    w[31:26] = cpuPkg::ALUR;
    w[25:18] = op2;
    w[11:8] = rd[3:0];
    w[7:4] = rs[3:0];
    w[3:0] = rt[3:0];
    return w;
  endfunction

  // Immediate format: op1 31:26, imm 23:8, rs 7:4, rt 3:0
  function automatic cpuPkg::word immInst(cpuPkg::op1Code op1, int rs, int rt,
                                          logic [15:0] imm);
    cpuPkg::word w;
    w = '0;
    w[31:26] = op1;
    w[23:8] = imm;
    w[7:4] = rs[3:0];
    w[3:0] = rt[3:0];
    return w;
  endfunction

  function automatic cpuPkg::word signExtend(logic [15:0] v);
    return {{16{v[15]}}, v};
  endfunction

  // Reference ALU, compares signed, shifts logical
  function automatic cpuPkg::word expectAlu(cpuPkg::op2Code op, cpuPkg::word a,
                                            cpuPkg::word b);
    case (op)
      cpuPkg::EQ:   return {31'b0, a == b};
      cpuPkg::LT:   return {31'b0, $signed(a) < $signed(b)};
      cpuPkg::LE:   return {31'b0, $signed(a) <= $signed(b)};
      cpuPkg::NE:   return {31'b0, a != b};
      cpuPkg::ADD:  return a + b;
      cpuPkg::AND:  return a & b;
      cpuPkg::OR:   return a | b;
      cpuPkg::XOR:  return a ^ b;
      cpuPkg::SUB:  return a - b;
      cpuPkg::NAND: return ~(a & b);
      cpuPkg::NOR:  return ~(a | b);
      cpuPkg::NXOR: return ~(a ^ b);
      cpuPkg::RSHF: return a >> b;
      cpuPkg::LSHF: return a << b;
      default:      return '0;
    endcase
  endfunction

  task automatic checkWord(input cpuPkg::word got, input cpuPkg::word exp, input string what);
    checkCount++;
    if (got !== exp) begin
      errorCount++;
      $display("Fail at %0d ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic checkBit(input logic got, input logic exp, input string what);
    checkCount++;
    if (got !== exp) begin
      errorCount++;
      $display("Fail at %0d ns: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic checkLedr(input logic [9:0] got, input logic [9:0] exp, input string what);
    checkCount++;
    if (got !== exp) begin
      errorCount++;
      $display("Fail at %0d ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  // Setup phase, then access phase sampled mid-cycle, then idle
  task automatic apbTransfer(input logic write, input cpuPkg::word addr,
                             input cpuPkg::word wdata, output cpuPkg::word rdata,
                             output logic err);
    @(negedge clk);
    apbIn = '{psel: 1'b1, penable: 1'b0, pwrite: write, paddr: addr, pwdata: wdata};
    @(negedge clk);
    apbIn.penable = 1'b1;
    #(clkPeriod / 4);
    checkBit(apbOut.pready, 1'b1, "pready in access phase");
    rdata = apbOut.prdata;
    err = apbOut.pslverr;
    @(negedge clk);
    apbIn = '0;
  endtask

  task automatic apbWrite(input cpuPkg::word addr, input cpuPkg::word data, output logic err);
    cpuPkg::word unused;
    apbTransfer(1'b1, addr, data, unused, err);
  endtask

  task automatic apbRead(input cpuPkg::word addr, output cpuPkg::word data, output logic err);
    apbTransfer(1'b0, addr, '0, data, err);
  endtask

  task automatic verifyDmem(input cpuPkg::word addr, input cpuPkg::word exp, input string what);
    cpuPkg::word data;
    logic err;
    apbRead(dmemBase + addr, data, err);
    checkBit(err, 1'b0, "pslverr on halted dmem read");
    checkWord(data, exp, what);
  endtask

  // Appends the self-branch, loads imem, runs, then halts the core
  task automatic runProgram();
    logic err;
    progWords.push_back(immInst(cpuPkg::BEQ, 0, 0, 16'h0));
    foreach (progWords[i]) begin
      apbWrite(imemBase + startPc + 4 * i, progWords[i], err);
      checkBit(err, 1'b0, "pslverr on imem load");
    end
    apbWrite(ctrlAddr, 32'd1, err);
    checkBit(err, 1'b0, "pslverr on run set");
    repeat (runCycles) @(posedge clk);
    apbWrite(ctrlAddr, 32'd0, err);
    checkBit(err, 1'b0, "pslverr on run clear");
  endtask

  task automatic pushFiller(input int count);
    for (int i = 0; i < count; i++) begin
      progWords.push_back(immInst(cpuPkg::ADDI, 0, 14, 16'h0));
    end
  endtask

  // Pair that a taken branch must skip
  task automatic pushSkipped();
    progWords.push_back(immInst(cpuPkg::ADDI, 0, 6, 16'h1));
    progWords.push_back(immInst(cpuPkg::ADDI, 0, 7, 16'h1));
  endtask

  task automatic reportTest(input string name, input int checksBefore, input int errorsBefore);
    $display("%s finished: %0d checks, %0d mismatches", name, checkCount - checksBefore,
             errorCount - errorsBefore);
  endtask

  task automatic aluTest();
    cpuPkg::op2Code ops [14];
    logic [15:0] ia;
    logic [15:0] ja;
    logic [15:0] ib;
    logic [15:0] jb;
    logic [4:0] shamt;
    cpuPkg::word a;
    cpuPkg::word b;
    int c0;
    int e0;
    c0 = checkCount;
    e0 = errorCount;
    ops = '{cpuPkg::EQ, cpuPkg::LT, cpuPkg::LE, cpuPkg::NE, cpuPkg::ADD, cpuPkg::AND,
            cpuPkg::OR, cpuPkg::XOR, cpuPkg::SUB, cpuPkg::NAND, cpuPkg::NOR, cpuPkg::NXOR,
            cpuPkg::RSHF, cpuPkg::LSHF};
    ia = 16'($urandom);
    ja = 16'($urandom);
    ib = 16'($urandom);
    jb = 16'($urandom);
    shamt = 5'($urandom);
    a = signExtend(ia) | signExtend(ja);
    b = signExtend(ib) | signExtend(jb);
    progWords.delete();
    progWords.push_back(immInst(cpuPkg::ADDI, 0, 1, ia));
    progWords.push_back(immInst(cpuPkg::ADDI, 0, 2, ib));
    progWords.push_back(immInst(cpuPkg::ADDI, 0, 3, {11'b0, shamt}));
    pushFiller(2);
    progWords.push_back(immInst(cpuPkg::ORI, 1, 1, ja));
    progWords.push_back(immInst(cpuPkg::ORI, 2, 2, jb));
    pushFiller(3);
    // Ten results in r4..r13, stored, then the last four reuse r4..r7
    for (int k = 0; k < 14; k++) begin
      progWords.push_back(aluInst(ops[k], 4 + k % 10, 1, (k >= 12) ? 3 : 2));
      if (k == 9 || k == 13) begin
        for (int j = (k == 9) ? 0 : 10; j <= k; j++) begin
          progWords.push_back(immInst(cpuPkg::SW, 0, 4 + j % 10, 16'(32'h200 + 4 * j)));
        end
      end
    end
    runProgram();
    for (int k = 0; k < 14; k++) begin
      verifyDmem(32'h200 + 4 * k, expectAlu(ops[k], a, (k >= 12) ? {27'b0, shamt} : b),
                 $sformatf("ALU %s result", ops[k].name()));
    end
    reportTest("aluTest", c0, e0);
  endtask

  task automatic forwardTest();
    logic [15:0] imm [4];
    cpuPkg::word val [9];
    int c0;
    int e0;
    c0 = checkCount;
    e0 = errorCount;
    foreach (imm[i]) begin
      imm[i] = 16'($urandom);
    end
    val[1] = signExtend(imm[0]);
    val[2] = val[1] + signExtend(imm[1]);
    val[3] = expectAlu(cpuPkg::ADD, val[1], val[2]);
    val[4] = expectAlu(cpuPkg::SUB, val[3], val[1]);
    val[5] = val[4] ^ signExtend(imm[2]);
    val[6] = expectAlu(cpuPkg::AND, val[5], val[3]);
    val[7] = val[6] | signExtend(imm[3]);
    val[8] = expectAlu(cpuPkg::NXOR, val[7], val[2]);
    progWords.delete();
    progWords.push_back(immInst(cpuPkg::ADDI, 0, 1, imm[0]));
    progWords.push_back(immInst(cpuPkg::ADDI, 1, 2, imm[1]));
    progWords.push_back(aluInst(cpuPkg::ADD, 3, 1, 2));
    progWords.push_back(aluInst(cpuPkg::SUB, 4, 3, 1));
    progWords.push_back(immInst(cpuPkg::XORI, 4, 5, imm[2]));
    progWords.push_back(aluInst(cpuPkg::AND, 6, 5, 3));
    progWords.push_back(immInst(cpuPkg::ORI, 6, 7, imm[3]));
    progWords.push_back(aluInst(cpuPkg::NXOR, 8, 7, 2));
    for (int r = 8; r >= 2; r--) begin
      progWords.push_back(immInst(cpuPkg::SW, 0, r, 16'(32'h300 + 4 * r)));
    end
    runProgram();
    for (int r = 2; r <= 8; r++) begin
      verifyDmem(32'h300 + 4 * r, val[r], $sformatf("forwarded r%0d", r));
    end
    reportTest("forwardTest", c0, e0);
  endtask

  task automatic loadUseTest();
    logic [15:0] v;
    logic [15:0] k;
    cpuPkg::word sum;
    int c0;
    int e0;
    c0 = checkCount;
    e0 = errorCount;
    v = 16'($urandom);
    k = 16'($urandom);
    sum = signExtend(v) + signExtend(k);
    progWords.delete();
    progWords.push_back(immInst(cpuPkg::ADDI, 0, 1, v));
    progWords.push_back(immInst(cpuPkg::SW, 0, 1, 16'h400));
    progWords.push_back(immInst(cpuPkg::LW, 0, 2, 16'h400));
    progWords.push_back(immInst(cpuPkg::ADDI, 2, 3, k));
    progWords.push_back(immInst(cpuPkg::SW, 0, 3, 16'h404));
    progWords.push_back(immInst(cpuPkg::LW, 0, 4, 16'h400));
    progWords.push_back(aluInst(cpuPkg::ADD, 5, 4, 3));
    progWords.push_back(immInst(cpuPkg::SW, 0, 5, 16'h408));
    progWords.push_back(immInst(cpuPkg::LW, 0, 6, 16'h400));
    progWords.push_back(immInst(cpuPkg::SW, 0, 6, 16'h40C));
    runProgram();
    verifyDmem(32'h400, signExtend(v), "stored word");
    verifyDmem(32'h404, sum, "load then ADDI");
    verifyDmem(32'h408, signExtend(v) + sum, "load then ALUR");
    verifyDmem(32'h40C, signExtend(v), "load then store");
    reportTest("loadUseTest", c0, e0);
  endtask

  task automatic branchTest();
    int n;
    int jalIndex;
    int c0;
    int e0;
    c0 = checkCount;
    e0 = errorCount;
    n = $urandom_range(20, 1);
    progWords.delete();
    progWords.push_back(immInst(cpuPkg::ADDI, 0, 6, 16'h0));
    progWords.push_back(immInst(cpuPkg::ADDI, 0, 7, 16'h0));
    progWords.push_back(immInst(cpuPkg::ADDI, 0, 1, 16'h0));
    progWords.push_back(immInst(cpuPkg::ADDI, 0, 2, 16'h1));
    progWords.push_back(immInst(cpuPkg::ADDI, 0, 3, 16'(n + 1)));
    // Sum loop closes with BLT back two words
    progWords.push_back(aluInst(cpuPkg::ADD, 1, 1, 2));
    progWords.push_back(immInst(cpuPkg::ADDI, 2, 2, 16'h1));
    progWords.push_back(immInst(cpuPkg::BLT, 2, 3, 16'hFFFE));
    progWords.push_back(immInst(cpuPkg::SW, 0, 1, 16'h500));
    progWords.push_back(immInst(cpuPkg::ADDI, 0, 5, 16'h11));
    progWords.push_back(immInst(cpuPkg::BEQ, 5, 5, 16'd3));
    pushSkipped();
    progWords.push_back(immInst(cpuPkg::BNE, 5, 0, 16'd3));
    pushSkipped();
    progWords.push_back(immInst(cpuPkg::BLE, 0, 5, 16'd3));
    pushSkipped();
    // Not-taken branches each let one marker bit through
    progWords.push_back(immInst(cpuPkg::BEQ, 5, 0, 16'd2));
    progWords.push_back(immInst(cpuPkg::ADDI, 0, 8, 16'h22));
    progWords.push_back(immInst(cpuPkg::BNE, 5, 5, 16'd2));
    progWords.push_back(immInst(cpuPkg::ORI, 8, 8, 16'h100));
    progWords.push_back(immInst(cpuPkg::BLE, 5, 0, 16'd2));
    progWords.push_back(immInst(cpuPkg::ORI, 8, 8, 16'h400));
    jalIndex = progWords.size();
    progWords.push_back(immInst(cpuPkg::JAL, 0, 10, 16'((startPc + 4 * (jalIndex + 3)) / 4)));
    pushSkipped();
    progWords.push_back(immInst(cpuPkg::SW, 0, 6, 16'h504));
    progWords.push_back(immInst(cpuPkg::SW, 0, 7, 16'h508));
    progWords.push_back(immInst(cpuPkg::SW, 0, 8, 16'h50C));
    progWords.push_back(immInst(cpuPkg::SW, 0, 10, 16'h510));
    runProgram();
    verifyDmem(32'h500, 32'(n * (n + 1) / 2), $sformatf("sum of 1..%0d", n));
    verifyDmem(32'h504, 32'h0, "first word after taken branch");
    verifyDmem(32'h508, 32'h0, "second word after taken branch");
    verifyDmem(32'h50C, 32'h522, "not-taken markers");
    verifyDmem(32'h510, startPc + 4 * jalIndex + 4, "JAL link");
    reportTest("branchTest", c0, e0);
  endtask

  task automatic ledrTest();
    logic [15:0] v;
    int c0;
    int e0;
    c0 = checkCount;
    e0 = errorCount;
    v = 16'($urandom);
    progWords.delete();
    progWords.push_back(immInst(cpuPkg::ADDI, 0, 1, v));
    // Sign-extended offset reaches the LED address from r0
    progWords.push_back(immInst(cpuPkg::SW, 0, 1, ledrAddr[15:0]));
    runProgram();
    checkLedr(ledr, v[9:0], "ledr after store");
    reportTest("ledrTest", c0, e0);
  endtask

  task automatic apbRulesTest();
    cpuPkg::word data;
    cpuPkg::word w;
    logic err;
    int c0;
    int e0;
    c0 = checkCount;
    e0 = errorCount;
    w = $urandom;
    apbWrite(ctrlAddr, 32'd1, err);
    checkBit(err, 1'b0, "pslverr on run set");
    apbRead(ctrlAddr, data, err);
    checkWord(data, 32'd1, "control readback while running");
    apbWrite(imemBase + startPc, $urandom, err);
    checkBit(err, 1'b1, "pslverr on imem write while running");
    apbRead(dmemBase + 32'h600, data, err);
    checkBit(err, 1'b1, "pslverr on dmem read while running");
    apbRead(unmappedAddr, data, err);
    checkBit(err, 1'b1, "pslverr on region 3 read");
    apbWrite(ctrlAddr + 32'h4, 32'd0, err);
    checkBit(err, 1'b1, "pslverr on control write at offset 4");
    apbWrite(ctrlAddr, 32'd0, err);
    checkBit(err, 1'b0, "pslverr on run clear");
    apbRead(ctrlAddr, data, err);
    checkWord(data, 32'd0, "control readback while halted");
    apbWrite(unmappedAddr + 32'h10, w, err);
    checkBit(err, 1'b1, "pslverr on region 3 write");
    apbWrite(dmemBase + 32'h600, w, err);
    checkBit(err, 1'b0, "pslverr on halted dmem write");
    verifyDmem(32'h600, w, "dmem word written over APB");
    reportTest("apbRulesTest", c0, e0);
  endtask

  initial begin
    void'($urandom(32'h2b5750a5));
    clk = 1'b0;
    reset = 1'b1;
    apbIn = '0;
    checkCount = 0;
    errorCount = 0;
    repeat (10) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    checkBit(apbOut.pslverr, 1'b0, "pslverr after reset");
    checkLedr(ledr, 10'h0, "ledr after reset");
    aluTest();
    forwardTest();
    loadUseTest();
    branchTest();
    ledrTest();
    apbRulesTest();
    $display("Totals: %0d checks, %0d mismatches", checkCount, errorCount);
    if (errorCount == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

  // Budget of 400 cycles for each test
  initial begin
    #(testCount * cyclesPerTest * clkPeriod);
    $display("Watchdog: tests did not finish within %0d ns, stopping the run",
             testCount * cyclesPerTest * clkPeriod);
    $display("ERRORS FOUND");
    $finish;
  end

endmodule

//--- all.f
hw/cpuPkg.sv
hw/fetchStage.sv
hw/decodeStage.sv
hw/executeStage.sv
hw/memoryStage.sv
hw/apbControl.sv
hw/pipelineCore.sv
testbench/coreTb.sv

//--- run.sh
#!/bin/sh
# Build the core testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1
logFile=sim.log

verilator --binary --timing -Wno-fatal --top-module coreTb -f all.f -o coreSim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/coreSim > "$logFile" 2>&1
simStatus=$?
cat "$logFile"
if [ $simStatus -ne 0 ]; then
  echo "Simulation exited with status $simStatus"
  exit 1
fi

if grep -q "ERRORS FOUND" "$logFile"; then
  exit 1
fi
exit 0
